/* vlog.f */
+incdir+src
src/cache_pkg.sv
src/cache_store.sv
src/cache_lookup.sv
src/cache_ctrl.sv
src/cache_result.sv
src/cache_top.sv
sim/cache_assert.sv
sim/cache_tb.sv

/* Makefile */
# Verilator build and run for the two-way data cache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module cache_tb

run: build
	@out="$$(./obj_dir/Vcache_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module cache_top

clean:
	rm -rf obj_dir

/* sim/cache_tb.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_tb;

    localparam int num_lines      = 2 ** (`CACHE_ADDR_W - `CACHE_OFFS_W);
    localparam int timeout_cycles = 200;

    logic                clk;
    logic                arst_n;
    logic                rd;
    logic                wr;
    cache_pkg::addr_t    addr;
    cache_pkg::word_t    wdata;
    logic                ready;
    logic                done;
    cache_pkg::word_t    rdata;
    cache_pkg::mem_req_t mem;
    logic                mem_ready;
    cache_pkg::line_t    mem_rdata;

    cache_pkg::line_t    mem_lines [num_lines];
    cache_pkg::word_t    shadow    [2 ** `CACHE_ADDR_W];
    cache_pkg::mem_req_t cur;
    cache_pkg::mem_req_t last_req;
    logic                busy = 1'b0;
    int                  wait_left = 0;
    int                  next_lat = 0;
    int                  mem_rd_cnt = 0;
    int                  mem_ready_cnt = 0;

    cache_top u_dut (
        .clk         (clk),
        .i_arst_n    (arst_n),
        .i_read      (rd),
        .i_write     (wr),
        .i_addr      (addr),
        .i_wdata     (wdata),
        .o_ready     (ready),
        .o_done      (done),
        .o_rdata     (rdata),
        .o_mem       (mem),
        .i_mem_ready (mem_ready),
        .i_mem_rdata (mem_rdata)
    );

    bind cache_top cache_assert u_assert (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_done      (o_done),
        .i_mem       (o_mem),
        .i_mem_ready (i_mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic cache_pkg::line_t shadow_line(input cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*16 +: 16] = shadow[{a[15:2], 2'(w)}];
        end
        return l;
    endfunction

    // Memory model answering one request after 1 to 8 cycles
    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #0.5;
            mem_ready = 1'b0;
            if (!busy && arst_n && (mem.rd || mem.wr)) begin
                busy      = 1'b1;
                cur       = mem;
                last_req  = mem;
                wait_left = (next_lat != 0) ? next_lat : $urandom_range(1, 8);
                next_lat  = 0;
                if (mem.rd) begin
                    mem_rd_cnt++;
                end else if (mem.line_wr) begin
                    assert (mem.addr[1:0] == 2'b00)
                    else fail_run($sformatf("line write address %h not aligned", mem.addr));
                    assert (mem.wdata == shadow_line(mem.addr))
                    else fail_run($sformatf("line write %h got %h expected %h",
                                            mem.addr, mem.wdata, shadow_line(mem.addr)));
                end
            end
            if (busy) begin
                assert (mem == cur) else fail_run("memory request changed before ready");
                wait_left--;
                if (wait_left == 0) begin
                    if (cur.rd) begin
                        mem_rdata = mem_lines[cur.addr[15:2]];
                    end else if (cur.line_wr) begin
                        mem_lines[cur.addr[15:2]] = cur.wdata;
                    end else begin
                        mem_lines[cur.addr[15:2]][cur.addr[1:0]*16 +: 16] = cur.wdata[15:0];
                    end
                    mem_ready = 1'b1;
                    mem_ready_cnt++;
                    busy = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (u_dut.u_assert.fail_cnt != 0) begin
            fail_run("a memory or done protocol property failed");
        end
    end

    // One CPU request from strobe to done with its latency in cycles after acceptance
    task automatic run_request(input logic is_wr, input cache_pkg::addr_t a,
                               input cache_pkg::word_t d, output int lat);
        cache_pkg::word_t exp;
        int               waited;
        rd     = !is_wr;
        wr     = is_wr;
        addr   = a;
        wdata  = d;
        waited = 0;
        while (!ready) begin
            @(posedge clk);
            #0.5;
            waited++;
            assert (waited < timeout_cycles) else fail_run("timeout waiting for ready");
        end
        @(posedge clk);
        #0.5;
        rd  = 1'b0;
        wr  = 1'b0;
        exp = shadow[a];
        if (is_wr) begin
            shadow[a] = d;
        end
        lat = 0;
        while (!done) begin
            @(posedge clk);
            #0.5;
            lat++;
            assert (lat < timeout_cycles) else fail_run("timeout waiting for done");
        end
        if (!is_wr) begin
            assert (rdata == exp)
            else fail_run($sformatf("read %h got %h expected %h", a, rdata, exp));
        end
    endtask

    task automatic directed_sequence();
        int lat;
        int cnt;
        run_request(1'b0, 16'h0011, '0, lat);
        cnt = mem_rd_cnt;
        run_request(1'b0, 16'h0011, '0, lat);
        assert (mem_rd_cnt == cnt && lat == 1)
        else fail_run($sformatf("repeated read took %0d cycles or read memory", lat));
        // X, Y, X, Z in set 0 leaves Y as the evicted line
        run_request(1'b0, 16'h0022, '0, lat);
        run_request(1'b0, 16'h0013, '0, lat);
        run_request(1'b0, 16'h0033, '0, lat);
        cnt = mem_rd_cnt;
        run_request(1'b0, 16'h0010, '0, lat);
        assert (mem_rd_cnt == cnt) else fail_run("read of X after Z missed");
        run_request(1'b0, 16'h0021, '0, lat);
        assert (mem_rd_cnt == cnt + 1) else fail_run("read of Y after Z did not miss");
        // Write hit with a slow line write behind it
        next_lat = 8;
        run_request(1'b1, 16'h0012, 16'hbeef, lat);
        assert (lat == 1 && ready && mem.wr && mem.line_wr)
        else fail_run("write hit did not start a background line write");
        cnt = mem_ready_cnt;
        run_request(1'b0, 16'h0012, '0, lat);
        assert (lat == 1 && mem_ready_cnt == cnt)
        else fail_run("read hit waited for the pending line write");
        run_request(1'b0, 16'h0045, '0, lat);
        assert (mem_ready_cnt == cnt + 2) else fail_run("miss overlapped the line write");
        // Write miss goes out as one word
        cnt      = mem_ready_cnt;
        next_lat = 4;
        run_request(1'b1, 16'h0106, 16'h5a3c, lat);
        assert (last_req.wr && !last_req.line_wr && last_req.addr == 16'h0106 &&
                last_req.wdata[15:0] == 16'h5a3c && mem_ready_cnt == cnt + 1)
        else fail_run("write miss did not send a single word write");
        cnt = mem_rd_cnt;
        run_request(1'b0, 16'h0106, '0, lat);
        assert (mem_rd_cnt == cnt + 1) else fail_run("write miss allocated the line");
    endtask

    initial begin
        int               lat;
        logic             is_wr;
        cache_pkg::addr_t a;
        cache_pkg::word_t d;
        void'($urandom(11));
        rd     = 1'b0;
        wr     = 1'b0;
        addr   = '0;
        wdata  = '0;
        arst_n = 1'b0;
        for (int l = 0; l < num_lines; l++) begin
            mem_lines[l] = {$urandom, $urandom};
            for (int w = 0; w < 4; w++) begin
                shadow[l*4 + w] = mem_lines[l][w*16 +: 16];
            end
        end
        repeat (16) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        assert (ready && !done && !mem.rd && !mem.wr)
        else fail_run("outputs not idle after reset");
        directed_sequence();
        // 16 lines spread over both sets
        repeat (400) begin
            a     = cache_pkg::addr_t'($urandom_range(0, 63));
            is_wr = ($urandom_range(0, 2) == 0);
            d     = cache_pkg::word_t'($urandom);
            run_request(is_wr, a, d, lat);
        end
        if (u_dut.u_assert.fail_cnt == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "memory or done protocol property failed");
        end
    end

endmodule

/* sim/cache_assert.sv */
`timescale 1ns/100ps

module cache_assert (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_done,
    input  cache_pkg::mem_req_t i_mem,
    input  logic                i_mem_ready
);

    // Number of failed properties so far
    int fail_cnt = 0;

    // One kind of memory access at a time
    strobe_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_mem.rd && i_mem.wr))
    else begin
        $error("memory read and write strobes are high together");
        fail_cnt++;
    end

    // Request held until memory answers
    req_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_mem.rd || i_mem.wr) && !i_mem_ready |=> $stable(i_mem))
    else begin
        $error("memory request changed while waiting for ready");
        fail_cnt++;
    end

    // Strobe drops on the edge that sees ready
    strobe_drop: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_mem.rd || i_mem.wr) && i_mem_ready |=> !(i_mem.rd || i_mem.wr))
    else begin
        $error("memory strobe still high after ready");
        fail_cnt++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_done |=> !i_done)
    else begin
        $error("done lasted more than one cycle");
        fail_cnt++;
    end

endmodule

/* src/cache_top.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_top (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_read,
    input  logic                i_write,
    input  cache_pkg::addr_t    i_addr,
    input  cache_pkg::word_t    i_wdata,
    output logic                o_ready,
    output logic                o_done,
    output cache_pkg::word_t    o_rdata,
    output cache_pkg::mem_req_t o_mem,
    input  logic                i_mem_ready,
    input  cache_pkg::line_t    i_mem_rdata
);

    cache_pkg::cpu_req_t                    req_q;
    cache_pkg::lookup_t                     look;
    logic             [`CACHE_WAYS-1:0]     valid;
    cache_pkg::tag_t  [`CACHE_WAYS-1:0]     tags;
    cache_pkg::way_t                        lru;
    cache_pkg::line_t [`CACHE_WAYS-1:0]     lines;
    logic                                   fill;
    cache_pkg::way_t                        fill_way;
    logic                                   upd;
    cache_pkg::way_t                        upd_way;
    logic                                   touch;
    cache_pkg::way_t                        touch_way;
    logic                                   take;
    logic                                   accept;
    cache_pkg::word_t                       read_word;
    cache_pkg::word_t                       fill_word;
    cache_pkg::line_t                       merged;

    assign accept = o_ready & (i_read | i_write);

    // Read wins when both strobes are up
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req_q <= '0;
        end else if (accept) begin
            req_q.read  <= i_read;
            req_q.write <= i_write & ~i_read;
            req_q.addr  <= i_addr;
            req_q.wdata <= i_wdata;
        end else if (take) begin
            // Address and data stay for the fill or write phase
            req_q.read  <= 1'b0;
            req_q.write <= 1'b0;
        end
    end

    cache_store u_store (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_req       (req_q),
        .i_fill      (fill),
        .i_fill_way  (fill_way),
        .i_fill_line (i_mem_rdata),
        .i_upd       (upd),
        .i_upd_way   (upd_way),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .o_valid     (valid),
        .o_tags      (tags),
        .o_lru       (lru),
        .o_lines     (lines)
    );

    cache_lookup u_lookup (
        .i_req   (req_q),
        .i_valid (valid),
        .i_tags  (tags),
        .i_lru   (lru),
        .o_look  (look)
    );

    cache_ctrl u_ctrl (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_req       (req_q),
        .i_look      (look),
        .i_mem_ready (i_mem_ready),
        .i_merged    (merged),
        .i_read_word (read_word),
        .i_fill_word (fill_word),
        .o_ready     (o_ready),
        .o_done      (o_done),
        .o_rdata     (o_rdata),
        .o_mem       (o_mem),
        .o_fill      (fill),
        .o_fill_way  (fill_way),
        .o_upd       (upd),
        .o_upd_way   (upd_way),
        .o_touch     (touch),
        .o_touch_way (touch_way),
        .o_accept    (take)
    );

    cache_result u_result (
        .i_req       (req_q),
        .i_look      (look),
        .i_lines     (lines),
        .i_mem_rdata (i_mem_rdata),
        .o_read_word (read_word),
        .o_fill_word (fill_word),
        .o_merged    (merged)
    );

endmodule

/* src/cache_result.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_result (
    input  cache_pkg::cpu_req_t                   i_req,
    input  cache_pkg::lookup_t                    i_look,
    input  cache_pkg::line_t [`CACHE_WAYS-1:0]    i_lines,
    input  cache_pkg::line_t                      i_mem_rdata,
    output cache_pkg::word_t                      o_read_word,
    output cache_pkg::word_t                      o_fill_word,
    output cache_pkg::line_t                      o_merged
);

    cache_pkg::line_t hit_line;
    int unsigned      lsb;

    // Bit position of the addressed word
    assign lsb      = i_look.offs * `CACHE_WORD_W;
    assign hit_line = i_lines[i_look.hit_way];

    // Word for a read hit
    assign o_read_word = hit_line[lsb +: `CACHE_WORD_W];

    // Same word taken from the line coming back on a miss
    assign o_fill_word = i_mem_rdata[lsb +: `CACHE_WORD_W];

    // Line sent to memory on a write hit
    always_comb begin
        o_merged = hit_line;
        o_merged[lsb +: `CACHE_WORD_W] = i_req.wdata;
    end

endmodule

/* src/cache_ctrl.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_ctrl (
    input  logic                clk,
    input  logic                i_arst_n,
    input  cache_pkg::cpu_req_t i_req,
    input  cache_pkg::lookup_t  i_look,
    input  logic                i_mem_ready,
    input  cache_pkg::line_t    i_merged,
    input  cache_pkg::word_t    i_read_word,
    input  cache_pkg::word_t    i_fill_word,
    output logic                o_ready,
    output logic                o_done,
    output cache_pkg::word_t    o_rdata,
    output cache_pkg::mem_req_t o_mem,
    output logic                o_fill,
    output cache_pkg::way_t     o_fill_way,
    output logic                o_upd,
    output cache_pkg::way_t     o_upd_way,
    output logic                o_touch,
    output cache_pkg::way_t     o_touch_way,
    output logic                o_accept
);

    cache_pkg::ctrl_state_t state_q;
    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_d;
    cache_pkg::addr_t       line_addr;
    logic                   pend_q;
    logic                   pend_left;
    logic                   req_vld;
    logic                   rd_hit;
    logic                   go;
    logic                   mem_done;

    assign req_vld = i_req.read | i_req.write;

    // A freshly registered request is looked up in the cycle after acceptance
    always_comb begin
        if ((state_q == cache_pkg::IDLE || state_q == cache_pkg::LINE_WR_HOLD) && req_vld) begin
            state = cache_pkg::LOOKUP;
        end else begin
            state = state_q;
        end
    end

    assign rd_hit    = i_req.read & i_look.hit;
    // Anything but a read hit needs the memory port free
    assign go        = (state == cache_pkg::LOOKUP) && (rd_hit || !pend_q);
    assign pend_left = pend_q & ~i_mem_ready;
    assign mem_done  = i_mem_ready &&
                       (state == cache_pkg::FILL_WAIT || state == cache_pkg::WORD_WR_WAIT);
    assign line_addr = {i_look.tag, i_look.idx, {`CACHE_OFFS_W{1'b0}}};

    assign o_ready     = (state == cache_pkg::IDLE) || (state == cache_pkg::LINE_WR_HOLD);
    assign o_accept    = go;
    assign o_touch     = go & i_look.hit;
    assign o_touch_way = i_look.hit_way;
    assign o_upd       = go & i_req.write & i_look.hit;
    assign o_upd_way   = i_look.hit_way;
    assign o_fill      = (state == cache_pkg::FILL_WAIT) & i_mem_ready;
    assign o_fill_way  = i_look.victim_way;

    always_comb begin
        state_d = state;
        case (state)
            cache_pkg::IDLE: begin
                state_d = cache_pkg::IDLE;
            end
            cache_pkg::LOOKUP: begin
                if (!go) begin
                    state_d = cache_pkg::LOOKUP;
                end else if (rd_hit) begin
                    state_d = pend_left ? cache_pkg::LINE_WR_HOLD : cache_pkg::IDLE;
                end else if (i_look.hit) begin
                    state_d = cache_pkg::LINE_WR_HOLD;
                end else if (i_req.read) begin
                    state_d = cache_pkg::FILL_WAIT;
                end else begin
                    state_d = cache_pkg::WORD_WR_WAIT;
                end
            end
            cache_pkg::FILL_WAIT, cache_pkg::WORD_WR_WAIT, cache_pkg::LINE_WR_HOLD: begin
                if (i_mem_ready) begin
                    state_d = cache_pkg::IDLE;
                end
            end
            default: begin
                state_d = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= cache_pkg::IDLE;
            pend_q  <= 1'b0;
            o_done  <= 1'b0;
            o_mem   <= '0;
        end else begin
            state_q <= state_d;
            o_done  <= (go & i_look.hit) | mem_done;
            pend_q  <= pend_left;
            if (i_mem_ready) begin
                o_mem.rd <= 1'b0;
                o_mem.wr <= 1'b0;
            end
            // Memory is idle here, so the raise never meets a drop
            if (go && !rd_hit) begin
                if (i_req.read) begin
                    o_mem.rd      <= 1'b1;
                    o_mem.line_wr <= 1'b1;
                    o_mem.addr    <= line_addr;
                    o_mem.wdata   <= '0;
                end else if (i_look.hit) begin
                    // Write-through of the merged line runs in the background
                    o_mem.wr      <= 1'b1;
                    o_mem.line_wr <= 1'b1;
                    o_mem.addr    <= line_addr;
                    o_mem.wdata   <= i_merged;
                    pend_q        <= 1'b1;
                end else begin
                    o_mem.wr      <= 1'b1;
                    o_mem.line_wr <= 1'b0;
                    o_mem.addr    <= i_req.addr;
                    o_mem.wdata   <= cache_pkg::line_t'(i_req.wdata);
                end
            end
        end
    end

    // Read data held until the next read completes
    always_ff @(posedge clk) begin
        if (go && rd_hit) begin
            o_rdata <= i_read_word;
        end else if (o_fill) begin
            o_rdata <= i_fill_word;
        end
    end

endmodule

/* src/cache_lookup.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_lookup (
    input  cache_pkg::cpu_req_t                  i_req,
    input  logic            [`CACHE_WAYS-1:0]    i_valid,
    input  cache_pkg::tag_t [`CACHE_WAYS-1:0]    i_tags,
    input  cache_pkg::way_t                      i_lru,
    output cache_pkg::lookup_t                   o_look
);

    cache_pkg::tag_t        tag;
    logic [`CACHE_WAYS-1:0] way_hit;

    assign tag = i_req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

    // Tag compare per way
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = i_valid[w] && (i_tags[w] == tag);
        end
    end

    always_comb begin
        o_look.hit  = |way_hit;
        o_look.idx  = i_req.addr[`CACHE_OFFS_W +: `CACHE_IDX_W];
        o_look.tag  = tag;
        o_look.offs = i_req.addr[`CACHE_OFFS_W-1:0];

        // At most one way can match
        if (way_hit[1]) begin
            o_look.hit_way = 1'b1;
        end else begin
            o_look.hit_way = 1'b0;
        end

        // Empty way first, else the LRU one
        if (!i_valid[0]) begin
            o_look.victim_way = 1'b0;
        end else if (!i_valid[1]) begin
            o_look.victim_way = 1'b1;
        end else begin
            o_look.victim_way = i_lru;
        end
    end

endmodule

/* src/cache_store.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_store (
    input  logic                                   clk,
    input  logic                                   i_arst_n,
    input  cache_pkg::cpu_req_t                    i_req,
    input  logic                                   i_fill,
    input  cache_pkg::way_t                        i_fill_way,
    input  cache_pkg::line_t                       i_fill_line,
    input  logic                                   i_upd,
    input  cache_pkg::way_t                        i_upd_way,
    input  logic                                   i_touch,
    input  cache_pkg::way_t                        i_touch_way,
    output logic             [`CACHE_WAYS-1:0]     o_valid,
    output cache_pkg::tag_t  [`CACHE_WAYS-1:0]     o_tags,
    output cache_pkg::way_t                        o_lru,
    output cache_pkg::line_t [`CACHE_WAYS-1:0]     o_lines
);

    cache_pkg::idx_t  idx;
    cache_pkg::tag_t  tag;
    cache_pkg::offs_t offs;

    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    // Way to replace next in each set
    cache_pkg::way_t        lru_q   [`CACHE_SETS];
    cache_pkg::tag_t        tags_q  [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::line_t       lines_q [`CACHE_SETS][`CACHE_WAYS];

    assign offs = i_req.addr[`CACHE_OFFS_W-1:0];
    assign idx  = i_req.addr[`CACHE_OFFS_W +: `CACHE_IDX_W];
    assign tag  = i_req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            if (i_fill) begin
                valid_q[idx][i_fill_way] <= 1'b1;
                lru_q[idx]               <= ~i_fill_way;
            end else if (i_touch) begin
                lru_q[idx] <= ~i_touch_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tags_q[idx][i_fill_way]  <= tag;
            lines_q[idx][i_fill_way] <= i_fill_line;
        end else if (i_upd) begin
            // Only the addressed word changes on a write hit
            lines_q[idx][i_upd_way][offs*`CACHE_WORD_W +: `CACHE_WORD_W] <= i_req.wdata;
        end
    end

    // Both ways of the addressed set
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            o_tags[w]  = tags_q[idx][w];
            o_lines[w] = lines_q[idx][w];
        end
    end

    assign o_valid = valid_q[idx];
    assign o_lru   = lru_q[idx];

endmodule

/* src/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    // Word 0 sits in the low bits
    typedef logic [`CACHE_LINE_W-1:0] line_t;
    typedef logic [`CACHE_TAG_W-1:0]  tag_t;
    typedef logic [`CACHE_OFFS_W-1:0] offs_t;
    typedef logic [`CACHE_IDX_W-1:0]  idx_t;
    typedef logic                     way_t;

    // Request as held by the top level
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  hit;
        way_t  hit_way;
        way_t  victim_way;
        idx_t  idx;
        tag_t  tag;
        offs_t offs;
    } lookup_t;

    // line_wr low means a single word in the low bits of wdata
    typedef struct packed {
        logic  rd;
        logic  wr;
        logic  line_wr;
        addr_t addr;
        line_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL_WAIT,
        WORD_WR_WAIT,
        LINE_WR_HOLD
    } ctrl_state_t;

endpackage

/* src/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// CPU word and word address
`define CACHE_WORD_W 16
`define CACHE_ADDR_W 16

// One line is four words
`define CACHE_LINE_W 64

// Address split into tag, index and offset
`define CACHE_TAG_W  13
`define CACHE_IDX_W  1
`define CACHE_OFFS_W 2

// Organization
`define CACHE_SETS 2
`define CACHE_WAYS 2

`endif
